// File: hdl/chess_macros.svh
`ifndef CHESS_MACROS_SVH
`define CHESS_MACROS_SVH

// board geometry
`define BOARD_SQUARES 64
`define SIDE_LEN 8

// successor board store
`define MAX_MOVES 256
`define MOVE_ADDR_W 8

`endif

// File: hdl/chess_pkg.sv
`include "chess_macros.svh"

package chess_pkg;

   typedef enum logic [2:0] {
      piece_empty  = 3'd0,
      piece_pawn   = 3'd1,
      piece_knight = 3'd2,
      piece_bishop = 3'd3,
      piece_rook   = 3'd4,
      piece_queen  = 3'd5,
      piece_king   = 3'd6
   } piece_kind_e;

   typedef struct packed {
      logic        black;
      piece_kind_e kind;
   } piece_t;

   // square n at bits n*4, n = row*8 + col
   typedef piece_t [`BOARD_SQUARES-1:0] board_t;

   typedef union packed {
      logic [5:0] index;
      struct packed {
         logic [2:0] row;
         logic [2:0] col;
      } rc;
   } square_u;

   typedef struct packed {
      logic   valid;
      board_t board;
   } move_wr_t;

   typedef struct packed {
      logic signed [2:0] dr;
      logic signed [2:0] dc;
   } offset_t;

   // orthogonal rays 0..3, diagonal rays 4..7
   localparam offset_t dir_offs [8] = '{
      '{ 3'sd0,  3'sd1}, '{ 3'sd0, -3'sd1}, '{ 3'sd1,  3'sd0}, '{-3'sd1,  3'sd0},
      '{ 3'sd1,  3'sd1}, '{ 3'sd1, -3'sd1}, '{-3'sd1,  3'sd1}, '{-3'sd1, -3'sd1}
   };

   // slider ray range by piece kind
   localparam logic [3:0] slider_first [8] = '{4'd0, 4'd0, 4'd0, 4'd4, 4'd0, 4'd0, 4'd0, 4'd0};
   localparam logic [3:0] slider_count [8] = '{4'd0, 4'd0, 4'd0, 4'd4, 4'd4, 4'd8, 4'd0, 4'd0};

   localparam offset_t knight_offs [8] = '{
      '{-3'sd2, -3'sd1}, '{-3'sd1, -3'sd2}, '{ 3'sd1, -3'sd2}, '{ 3'sd2, -3'sd1},
      '{ 3'sd2,  3'sd1}, '{ 3'sd1,  3'sd2}, '{-3'sd1,  3'sd2}, '{-3'sd2,  3'sd1}
   };

   localparam offset_t king_offs [8] = dir_offs; // one step along every ray

endpackage

// File: hdl/move_generator.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module move_generator (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  chess_pkg::board_t   board,
   input  logic                white_to_move,
   output chess_pkg::move_wr_t wr,
   output logic                done
);
   import chess_pkg::*;

   typedef enum logic [1:0] {g_idle, g_pick, g_slide, g_step} gen_state_e;

   gen_state_e                state;
   logic [`BOARD_SQUARES-1:0] mask;
   square_u                   sq, low_sq, tsq;
   piece_t                    pc, low_pc, tp;
   logic [3:0]                k, first_k, slide_end;
   logic signed [4:0]         cur_r, cur_c, tr, tc, org_r, org_c, low_r, low_c;
   logic signed [4:0]         fwd, pawn_dc;
   offset_t                   step_off;
   logic                      mover_black, in_bounds, tgt_empty, tgt_enemy, tgt_ok;
   logic                      last_step;
   board_t                    moved;

   assign mover_black = ~white_to_move;

   always_comb
   begin
      low_sq.index = '0;
      for (int s = `BOARD_SQUARES - 1; s >= 0; s--)
         if (mask[s])
            low_sq.index = s[5:0]; // lowest set bit wins
      low_pc  = board[low_sq.index];
      low_r   = $signed({2'b00, low_sq.rc.row});
      low_c   = $signed({2'b00, low_sq.rc.col});
      first_k = slider_first[low_pc.kind];

      org_r     = $signed({2'b00, sq.rc.row});
      org_c     = $signed({2'b00, sq.rc.col});
      slide_end = slider_first[pc.kind] + slider_count[pc.kind];
      step_off  = (pc.kind == piece_knight) ? knight_offs[k[2:0]] : king_offs[k[2:0]];
      fwd       = white_to_move ? 5'sd1 : -5'sd1;
      pawn_dc   = (k == 4'd1) ? -5'sd1 : (k == 4'd2) ? 5'sd1 : 5'sd0;

      if (state == g_slide)
      begin
         tr = cur_r;
         tc = cur_c;
      end
      else if (pc.kind == piece_pawn)
      begin
         tr = org_r + fwd;
         tc = org_c + pawn_dc; // k 0 advance, 1 and 2 captures
      end
      else
      begin
         tr = org_r + step_off.dr;
         tc = org_c + step_off.dc;
      end

      tsq.rc.row = tr[2:0];
      tsq.rc.col = tc[2:0];
      tp         = board[tsq.index];
      in_bounds  = tr >= 0 && tr < `SIDE_LEN && tc >= 0 && tc < `SIDE_LEN;
      tgt_empty  = tp.kind == piece_empty;
      tgt_enemy  = !tgt_empty && tp.black != mover_black;

      if (state == g_step && pc.kind == piece_pawn)
         tgt_ok = in_bounds && ((k == 4'd0) ? tgt_empty : tgt_enemy);
      else
         tgt_ok = in_bounds && (tgt_empty || tgt_enemy);
      last_step = (pc.kind == piece_pawn) ? (k == 4'd2) : (k == 4'd7);

      moved            = board;
      moved[sq.index]  = '0;
      moved[tsq.index] = pc;
   end

   always_ff @(posedge clk)
   begin
      wr.board <= moved; // payload free-runs, qualified by valid
      if (reset)
      begin
         state    <= g_idle;
         wr.valid <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         wr.valid <= 1'b0;
         done     <= 1'b0;
         case (state)
            g_idle:
               if (start)
               begin
                  for (int s = 0; s < `BOARD_SQUARES; s++)
                     mask[s] <= board[s].kind != piece_empty && board[s].black == mover_black;
                  state <= g_pick;
               end
            g_pick:
               if (mask == '0)
               begin
                  done  <= 1'b1;
                  state <= g_idle;
               end
               else
               begin
                  sq <= low_sq;
                  pc <= low_pc;
                  if (slider_count[low_pc.kind] != 4'd0)
                  begin
                     k     <= first_k;
                     cur_r <= low_r + dir_offs[first_k[2:0]].dr;
                     cur_c <= low_c + dir_offs[first_k[2:0]].dc;
                     state <= g_slide;
                  end
                  else
                  begin
                     k     <= 4'd0;
                     state <= g_step;
                  end
               end
            g_slide:
            begin
               wr.valid <= tgt_ok;
               if (tgt_ok && tgt_empty)
               begin
                  cur_r <= cur_r + dir_offs[k[2:0]].dr;
                  cur_c <= cur_c + dir_offs[k[2:0]].dc;
               end
               else if (k + 4'd1 == slide_end)
               begin
                  mask[sq.index] <= 1'b0;
                  state          <= g_pick;
               end
               else
               begin
                  k     <= k + 4'd1; // edge, own piece or capture ends the ray
                  cur_r <= org_r + dir_offs[k[2:0] + 3'd1].dr;
                  cur_c <= org_c + dir_offs[k[2:0] + 3'd1].dc;
               end
            end
            g_step:
            begin
               wr.valid <= tgt_ok;
               k        <= k + 4'd1;
               if (last_step)
               begin
                  mask[sq.index] <= 1'b0;
                  state          <= g_pick;
               end
            end
            default:
               state <= g_idle;
         endcase
      end
   end

   a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
      start |-> state == g_idle);

endmodule

// File: hdl/move_store.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module move_store (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    restart,
   input  chess_pkg::move_wr_t     wr,
   input  logic [`MOVE_ADDR_W-1:0] rd_addr,
   output chess_pkg::board_t       rd_data,
   output logic [`MOVE_ADDR_W:0]   count
);
   import chess_pkg::*;

   board_t mem [`MAX_MOVES];

   always_ff @(posedge clk)
   begin
      rd_data <= mem[rd_addr];
      if (wr.valid)
         mem[count[`MOVE_ADDR_W-1:0]] <= wr.board;
   end

   // write pointer doubles as the entry count
   always_ff @(posedge clk)
   begin
      if (reset || restart)
         count <= '0;
      else if (wr.valid)
         count <= count + 1'b1;
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      wr.valid |-> count < `MAX_MOVES);

endmodule

// File: hdl/check_detector.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module check_detector (
   input  logic              clk,
   input  logic              reset,
   input  logic              req,
   input  chess_pkg::board_t test_board,
   input  logic              king_black,
   output logic              ack,
   output logic              in_check
);
   import chess_pkg::*;

   typedef enum logic [2:0] {c_idle, c_find, c_near, c_ray, c_hold} chk_state_e;

   chk_state_e        state;
   square_u           king_sq, found_sq, ray_sq;
   logic              found, near_hit, ray_in, ray_hit;
   logic [2:0]        k;
   logic signed [4:0] kr, kc, cur_r, cur_c, pawn_dr;
   piece_t            own_king, foe_knight, foe_king, foe_pawn, ray_pc;

   function automatic logic holds(input board_t b, input logic signed [4:0] r,
                                  input logic signed [4:0] c, input piece_t p);
      square_u s;
      s.rc.row = r[2:0];
      s.rc.col = c[2:0];
      return r >= 0 && r < `SIDE_LEN && c >= 0 && c < `SIDE_LEN && b[s.index] == p;
   endfunction

   assign own_king   = '{black: king_black, kind: piece_king};
   assign foe_knight = '{black: ~king_black, kind: piece_knight};
   assign foe_king   = '{black: ~king_black, kind: piece_king};
   assign foe_pawn   = '{black: ~king_black, kind: piece_pawn};
   assign pawn_dr    = king_black ? -5'sd1 : 5'sd1; // white pawns sit below a black king

   always_comb
   begin
      found          = 1'b0;
      found_sq.index = '0;
      for (int s = 0; s < `BOARD_SQUARES; s++)
         if (test_board[s] == own_king)
         begin
            found          = 1'b1;
            found_sq.index = s[5:0];
         end

      kr = $signed({2'b00, king_sq.rc.row});
      kc = $signed({2'b00, king_sq.rc.col});

      near_hit = holds(test_board, kr + pawn_dr, kc - 5'sd1, foe_pawn) ||
                 holds(test_board, kr + pawn_dr, kc + 5'sd1, foe_pawn);
      for (int i = 0; i < 8; i++)
         near_hit = near_hit ||
            holds(test_board, kr + knight_offs[i].dr, kc + knight_offs[i].dc, foe_knight) ||
            holds(test_board, kr + king_offs[i].dr, kc + king_offs[i].dc, foe_king);

      ray_sq.rc.row = cur_r[2:0];
      ray_sq.rc.col = cur_c[2:0];
      ray_pc        = test_board[ray_sq.index];
      ray_in        = cur_r >= 0 && cur_r < `SIDE_LEN && cur_c >= 0 && cur_c < `SIDE_LEN;
      ray_hit       = ray_pc.black != king_black &&
                      (ray_pc.kind == piece_queen ||
                       (k[2] ? ray_pc.kind == piece_bishop : ray_pc.kind == piece_rook));
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= c_idle;
         ack      <= 1'b0;
         in_check <= 1'b0;
      end
      else
         case (state)
            c_idle:
               if (req)
                  state <= c_find;
            c_find:
            begin
               king_sq <= found_sq;
               if (!found)
               begin
                  in_check <= 1'b1; // missing king counts as lost
                  ack      <= 1'b1;
                  state    <= c_hold;
               end
               else
                  state <= c_near;
            end
            c_near:
               if (near_hit)
               begin
                  in_check <= 1'b1;
                  ack      <= 1'b1;
                  state    <= c_hold;
               end
               else
               begin
                  k     <= 3'd0;
                  cur_r <= kr + dir_offs[0].dr;
                  cur_c <= kc + dir_offs[0].dc;
                  state <= c_ray;
               end
            c_ray:
               if (ray_in && ray_pc.kind == piece_empty)
               begin
                  cur_r <= cur_r + dir_offs[k].dr;
                  cur_c <= cur_c + dir_offs[k].dc;
               end
               else if (ray_in && ray_hit)
               begin
                  in_check <= 1'b1;
                  ack      <= 1'b1;
                  state    <= c_hold;
               end
               else if (k == 3'd7)
               begin
                  in_check <= 1'b0; // all rays clear
                  ack      <= 1'b1;
                  state    <= c_hold;
               end
               else
               begin
                  k     <= k + 3'd1;
                  cur_r <= kr + dir_offs[k + 3'd1].dr;
                  cur_c <= kc + dir_offs[k + 3'd1].dc;
               end
            c_hold:
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= c_idle;
               end
            default:
               state <= c_idle;
         endcase
   end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> req);

endmodule

// File: hdl/legal_move_search.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module legal_move_search (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    gen_done,
   input  logic [`MOVE_ADDR_W:0]   count,
   input  logic                    white_to_move,
   output logic [`MOVE_ADDR_W-1:0] rd_addr,
   input  chess_pkg::board_t       rd_data,
   output logic                    req,
   output chess_pkg::board_t       test_board,
   output logic                    king_black,
   input  logic                    ack,
   input  logic                    in_check,
   output logic                    no_legal_move,
   output logic                    result_valid
);
   typedef enum logic [2:0] {s_idle, s_addr, s_load, s_ack, s_drop} srch_state_e;

   srch_state_e state;
   logic        legal;

   assign king_black = ~white_to_move; // test the mover's own king

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= s_idle;
         req           <= 1'b0;
         no_legal_move <= 1'b0;
         result_valid  <= 1'b0;
      end
      else
      begin
         result_valid <= 1'b0;
         case (state)
            s_idle:
               if (gen_done)
               begin
                  rd_addr <= '0;
                  if (count == '0)
                  begin
                     no_legal_move <= 1'b1; // nothing to try
                     result_valid  <= 1'b1;
                  end
                  else
                     state <= s_addr;
               end
            s_addr:
               state <= s_load; // store read latency
            s_load:
            begin
               test_board <= rd_data;
               req        <= 1'b1;
               state      <= s_ack;
            end
            s_ack:
               if (ack)
               begin
                  req   <= 1'b0;
                  legal <= !in_check;
                  state <= s_drop;
               end
            s_drop:
               if (!ack)
               begin
                  if (legal || {1'b0, rd_addr} == count - 1'b1)
                  begin
                     no_legal_move <= !legal;
                     result_valid  <= 1'b1;
                     state         <= s_idle;
                  end
                  else
                  begin
                     rd_addr <= rd_addr + 1'b1;
                     state   <= s_addr;
                  end
               end
            default:
               state <= s_idle;
         endcase
      end
   end

endmodule

// File: hdl/mate_detector.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module mate_detector (
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  chess_pkg::board_t board,
   input  logic              white_to_move,
   input  logic              clear,
   output logic              no_legal_move,
   output logic              no_legal_move_valid
);
   import chess_pkg::*;

   typedef enum logic [1:0] {t_idle, t_busy, t_result} top_state_e;

   top_state_e              state;
   board_t                  board_r, rd_data, test_board;
   logic                    white_r, valid_z, start;
   move_wr_t                wr;
   logic                    gen_done, req, ack, in_check, king_black;
   logic                    srch_result, srch_valid;
   logic [`MOVE_ADDR_W:0]   count;
   logic [`MOVE_ADDR_W-1:0] rd_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state               <= t_idle;
         valid_z             <= 1'b0;
         start               <= 1'b0;
         no_legal_move       <= 1'b0;
         no_legal_move_valid <= 1'b0;
      end
      else
      begin
         valid_z <= board_valid;
         start   <= 1'b0;
         case (state)
            t_idle:
            begin
               board_r <= board;
               white_r <= white_to_move;
               if (board_valid && !valid_z)
               begin
                  start <= 1'b1; // rising edge only
                  state <= t_busy;
               end
            end
            t_busy:
               if (srch_valid)
               begin
                  no_legal_move       <= srch_result;
                  no_legal_move_valid <= 1'b1;
                  state               <= t_result;
               end
            t_result:
               if (clear)
               begin
                  no_legal_move       <= 1'b0;
                  no_legal_move_valid <= 1'b0;
                  state               <= t_idle;
               end
            default:
               state <= t_idle;
         endcase
      end
   end

   move_generator u_gen (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .board         (board_r),
      .white_to_move (white_r),
      .wr            (wr),
      .done          (gen_done)
   );

   move_store u_store (
      .clk     (clk),
      .reset   (reset),
      .restart (start),
      .wr      (wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .count   (count)
   );

   legal_move_search u_search (
      .clk           (clk),
      .reset         (reset),
      .gen_done      (gen_done),
      .count         (count),
      .white_to_move (white_r),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data),
      .req           (req),
      .test_board    (test_board),
      .king_black    (king_black),
      .ack           (ack),
      .in_check      (in_check),
      .no_legal_move (srch_result),
      .result_valid  (srch_valid)
   );

   check_detector u_check (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .test_board (test_board),
      .king_black (king_black),
      .ack        (ack),
      .in_check   (in_check)
   );

endmodule

// File: sim/tb_mate_detector.sv
`timescale 1ns/1ps
`include "chess_macros.svh"

module tb_mate_detector;
   import chess_pkg::*;

   localparam int max_cycles = 20000; // 19 runs under 1000 cycles each plus the idle watch
   localparam int idle_watch = 300;   // longer than one whole stalemate run
   localparam logic [31:0] lfsr_seed = 32'hc0ea;

   logic   clk;
   logic   reset;
   logic   board_valid;
   board_t board;
   logic   white_to_move;
   logic   clear;
   logic   no_legal_move;
   logic   no_legal_move_valid;

   int          cycles = 0;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   logic [31:0] lfsr;

   mate_detector uut (
      .clk                 (clk),
      .reset               (reset),
      .board_valid         (board_valid),
      .board               (board),
      .white_to_move       (white_to_move),
      .clear               (clear),
      .no_legal_move       (no_legal_move),
      .no_legal_move_valid (no_legal_move_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= max_cycles)
      begin
         $display("timeout: no result after %0d cycles, the DUT appears hung", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output logic [5:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr); // one step per bit
         v    = {v[4:0], lfsr[0]};
      end
   endtask

   function automatic logic kings_touch(input logic [5:0] a, input logic [5:0] b);
      int dr;
      int dc;
      dr = int'(a[5:3]) - int'(b[5:3]);
      dc = int'(a[2:0]) - int'(b[2:0]);
      return dr >= -1 && dr <= 1 && dc >= -1 && dc <= 1;
   endfunction

   function automatic board_t place(input board_t b, input int row, input int col,
                                    input logic black, input piece_kind_e kind);
      board_t nb;
      nb = b;
      nb[row * `SIDE_LEN + col].black = black;
      nb[row * `SIDE_LEN + col].kind  = kind;
      return nb;
   endfunction

   function automatic board_t stalemate_board();
      board_t b;
      b = '0;
      b = place(b, 7, 7, 1'b1, piece_king);
      b = place(b, 5, 6, 1'b0, piece_queen); // covers every flight square
      b = place(b, 0, 0, 1'b0, piece_king);
      return b;
   endfunction

   task automatic check_result(input logic got, input logic exp, input string name);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_idle(input string name);
      logic fell;
      fell = 1'b0;
      for (int i = 0; i < 2 && !fell; i++)
      begin
         @(posedge clk);
         #1;
         fell = !no_legal_move_valid;
      end
      checks++;
      if (!fell)
      begin
         errors++;
         $display("MISMATCH at %0t: %s valid still high 2 cycles after clear", $time, name);
      end
   endtask

   task automatic evaluate(input board_t b, input logic wtm, input logic exp,
                           input string name);
      board         = b;
      white_to_move = wtm;
      board_valid   = 1'b1;
      do
      begin
         @(posedge clk);
         #1;
      end
      while (!no_legal_move_valid);
      check_result(no_legal_move, exp, name);
   endtask

   task automatic release_result(input logic keep_valid, input string name);
      clear = 1'b1;
      if (!keep_valid)
         board_valid = 1'b0;
      check_idle(name);
      clear = 1'b0;
   endtask

   task automatic run_case(input board_t b, input logic wtm, input logic exp,
                           input string name);
      evaluate(b, wtm, exp, name);
      release_result(1'b0, name);
   endtask

   task automatic report(input string name, input int errors_before);
      tests++;
      $display("%s: %s", name, (errors == errors_before) ? "ok" : "FAIL");
   endtask

   task automatic lone_kings();
      board_t b;
      int     e0;
      e0 = errors;
      b  = '0;
      b  = place(b, 0, 0, 1'b0, piece_king);
      b  = place(b, 7, 7, 1'b1, piece_king);
      run_case(b, 1'b1, 1'b0, "lone kings, white to move");
      run_case(b, 1'b0, 1'b0, "lone kings, black to move");
      report("lone_kings", e0);
   endtask

   task automatic back_rank();
      board_t b;
      int     e0;
      e0 = errors;
      b  = '0;
      b  = place(b, 7, 7, 1'b1, piece_king);
      b  = place(b, 6, 6, 1'b1, piece_pawn);
      b  = place(b, 6, 7, 1'b1, piece_pawn);
      b  = place(b, 0, 0, 1'b0, piece_king);
      run_case(place(b, 7, 0, 1'b0, piece_rook), 1'b0, 1'b1, "back rank mate");
      run_case(place(b, 0, 3, 1'b0, piece_rook), 1'b0, 1'b0, "back rank, rook away");
      report("back_rank", e0);
   endtask

   task automatic stalemate();
      int e0;
      e0 = errors;
      run_case(stalemate_board(), 1'b0, 1'b1, "stalemate");
      report("stalemate", e0);
   endtask

   task automatic pawn_knight_checks();
      board_t b;
      int     e0;
      e0 = errors;
      b  = '0;
      b  = place(b, 7, 7, 1'b1, piece_king);
      b  = place(b, 6, 6, 1'b0, piece_pawn); // checks the king, which can take it
      b  = place(b, 0, 0, 1'b0, piece_king);
      run_case(b, 1'b0, 1'b0, "pawn check, capturable");
      b = '0;
      b = place(b, 0, 0, 1'b0, piece_king);
      b = place(b, 0, 1, 1'b0, piece_pawn);
      b = place(b, 1, 1, 1'b0, piece_pawn);
      b = place(b, 1, 0, 1'b0, piece_rook); // a pawn here would take the knight
      b = place(b, 2, 1, 1'b1, piece_knight);
      b = place(b, 7, 7, 1'b1, piece_king);
      run_case(b, 1'b1, 1'b1, "smothered knight mate");
      report("pawn_knight", e0);
   endtask

   task automatic random_kings();
      board_t     b;
      logic [5:0] w_sq;
      logic [5:0] b_sq;
      logic [5:0] side;
      int         e0;
      e0 = errors;
      for (int n = 0; n < 10; n++)
      begin
         do
         begin
            draw_bits(6, w_sq);
            draw_bits(6, b_sq);
         end
         while (kings_touch(w_sq, b_sq));
         draw_bits(1, side);
         b = '0;
         b = place(b, int'(w_sq[5:3]), int'(w_sq[2:0]), 1'b0, piece_king);
         b = place(b, int'(b_sq[5:3]), int'(b_sq[2:0]), 1'b1, piece_king);
         run_case(b, side[0], 1'b0, $sformatf("random kings %0d", n));
      end
      report("random_kings", e0);
   endtask

   task automatic restart_after_clear();
      logic started;
      int   e0;
      e0 = errors;
      evaluate(stalemate_board(), 1'b0, 1'b1, "restart, first run");
      release_result(1'b1, "restart, first run");
      started = 1'b0;
      repeat (idle_watch)
      begin
         @(posedge clk);
         #1;
         if (no_legal_move_valid)
            started = 1'b1;
      end
      checks++;
      if (started)
      begin
         errors++;
         $display("at %0t: a new evaluation began while board_valid stayed high", $time);
      end
      board_valid = 1'b0;
      @(posedge clk);
      #1;
      run_case(stalemate_board(), 1'b0, 1'b1, "restart, second run");
      report("restart", e0);
   endtask

   initial
   begin
      reset         = 1'b1;
      board_valid   = 1'b0;
      board         = '0;
      white_to_move = 1'b1;
      clear         = 1'b0;
      lfsr          = lfsr_seed;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      check_result(no_legal_move_valid, 1'b0, "valid after reset");
      check_result(no_legal_move, 1'b0, "result after reset");
      lone_kings();
      back_rank();
      stalemate();
      pawn_knight_checks();
      random_kings();
      restart_after_clear();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: files.f
+incdir+hdl
hdl/chess_pkg.sv
hdl/move_generator.sv
hdl/move_store.sv
hdl/check_detector.sv
hdl/legal_move_search.sv
hdl/mate_detector.sv
sim/tb_mate_detector.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mate_detector
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
